// ==== vga_pkg.sv ====
`default_nettype none

package vga_pkg;

    // Horizontal timing in pixel clocks
    localparam int h_visible = 640;
    localparam int h_front   = 16;
    localparam int h_sync    = 96;
    localparam int h_back    = 48;
    localparam int h_total   = 800;

    // Vertical timing in lines
    localparam int v_visible = 480;
    localparam int v_front   = 10;
    localparam int v_sync    = 2;
    localparam int v_back    = 33;
    localparam int v_total   = 525;

    // Sync pulse windows, end is exclusive
    localparam int h_sync_start = h_visible + h_front;
    localparam int h_sync_end   = h_sync_start + h_sync;
    localparam int v_sync_start = v_visible + v_front;
    localparam int v_sync_end   = v_sync_start + v_sync;

    localparam int coord_w = 10;
    localparam int bar_w   = h_visible / 8;  // Eight colour bars across the line

    typedef enum logic [1:0] {
        mode_solid = 2'd0,
        mode_text  = 2'd1,
        mode_bars  = 2'd2,
        mode_blue  = 2'd3
    } color_mode_t;

    typedef struct packed {
        color_mode_t mode;      // Bits 31:30
        logic [5:0]  color;     // Bits 29:24, rr gg bb
        logic [23:0] reserved;
    } vga_cfg_t;

    typedef struct packed {
        logic [1:0] r;
        logic [1:0] g;
        logic [1:0] b;
    } rgb_t;

    typedef struct packed {
        logic [coord_w-1:0] x;
        logic [coord_w-1:0] y;
        logic               active;
        logic               hs;      // Active low
        logic               vs;      // Active low
    } scan_pos_t;

    typedef struct packed {
        logic [coord_w-1:0] x;       // Kept for the bar pattern
        logic               glyph_on;
        logic               active;
        logic               hs;
        logic               vs;
    } cell_pix_t;

    localparam vga_cfg_t cfg_reset_value = '{
        mode:     mode_text,
        color:    6'b111111,
        reserved: 24'd0
    };

endpackage

`default_nettype wire

// ==== vga_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
    input  wire                clk,
    input  wire                rst_n,
    output vga_pkg::scan_pos_t pos,
    output logic               frame_start
);
    import vga_pkg::*;

    logic [coord_w-1:0] h_cnt;
    logic [coord_w-1:0] v_cnt;
    logic               h_last;
    logic               v_last;
    logic               in_hsync;
    logic               in_vsync;
    logic               in_active;

    assign h_last = (h_cnt == coord_w'(h_total - 1));
    assign v_last = (v_cnt == coord_w'(v_total - 1));

    assign in_hsync  = (h_cnt >= coord_w'(h_sync_start)) && (h_cnt < coord_w'(h_sync_end));
    assign in_vsync  = (v_cnt >= coord_w'(v_sync_start)) && (v_cnt < coord_w'(v_sync_end));
    assign in_active = (h_cnt < coord_w'(h_visible)) && (v_cnt < coord_w'(v_visible));

    // Free-running pixel and line counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            if (v_last) begin
                v_cnt <= '0;  // Wrap to top of frame
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Outputs lag the counters by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pos <= '{x: '0, y: '0, active: 1'b0, hs: 1'b1, vs: 1'b1};
            frame_start <= 1'b0;
        end else begin
            pos.x      <= h_cnt;
            pos.y      <= v_cnt;
            pos.active <= in_active;
            pos.hs     <= ~in_hsync;  // Syncs are active low
            pos.vs     <= ~in_vsync;
            frame_start <= (h_cnt == '0) && (v_cnt == '0);  // Aligned with pos at origin
        end
    end

endmodule

`default_nettype wire

// ==== cell_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module cell_decode (
    input  wire                clk,
    input  wire                rst_n,
    input  wire vga_pkg::scan_pos_t pos,
    output vga_pkg::cell_pix_t pix
);
    import vga_pkg::*;

    logic [1:0] cell_col_lsb;  // Low bits of x/8
    logic [1:0] cell_row_lsb;  // Low bits of y/8
    logic [2:0] px;
    logic [2:0] py;
    logic [1:0] char_code;
    logic       glyph_on;

    // Fixed 8x8 glyph set, four characters
    function automatic logic glyph_bit(input logic [1:0] k, input logic [2:0] cx,
                                       input logic [2:0] cy);
        logic [2:0] diff;
        diff = cx ^ cy;
        if (k == 2'd3) begin
            return (cx == cy);  // Diagonal stroke
        end
        return diff[k];
    endfunction

    assign cell_col_lsb = pos.x[4:3];
    assign cell_row_lsb = pos.y[4:3];
    assign px           = pos.x[2:0];
    assign py           = pos.y[2:0];

    // Character code is (column + row) mod 4
    assign char_code = cell_col_lsb + cell_row_lsb;
    assign glyph_on  = glyph_bit(char_code, px, py);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pix <= '{x: '0, glyph_on: 1'b0, active: 1'b0, hs: 1'b1, vs: 1'b1};
        end else begin
            pix.x        <= pos.x;
            pix.glyph_on <= glyph_on;
            pix.active   <= pos.active;
            pix.hs       <= pos.hs;  // Syncs follow the pixel
            pix.vs       <= pos.vs;
        end
    end

endmodule

`default_nettype wire

// ==== pixel_color.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_color (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire vga_pkg::cell_pix_t pix,
    input  wire vga_pkg::vga_cfg_t  cfg,
    output vga_pkg::rgb_t           rgb,
    output logic                    hs,
    output logic                    vs
);
    import vga_pkg::*;

    localparam rgb_t black     = '{r: 2'b00, g: 2'b00, b: 2'b00};
    localparam rgb_t pure_blue = '{r: 2'b00, g: 2'b00, b: 2'b11};

    logic [2:0] bar;
    rgb_t       cfg_color;
    rgb_t       bar_color;
    rgb_t       rgb_next;

    // x / 80 by comparison against the bar edges
    function automatic logic [2:0] bar_index(input logic [coord_w-1:0] x);
        logic [2:0] idx;
        idx = 3'd0;
        for (int i = 1; i < 8; i++) begin
            if (x >= coord_w'(i * bar_w)) begin
                idx = 3'(i);
            end
        end
        return idx;
    endfunction

    assign bar       = bar_index(pix.x);
    assign cfg_color = rgb_t'(cfg.color);

    // Each bar index bit drives one colour at full level
    assign bar_color = '{
        r: {bar[2], bar[2]},
        g: {bar[1], bar[1]},
        b: {bar[0], bar[0]}
    };

    always_comb begin
        rgb_next = black;
        if (pix.active) begin
            case (cfg.mode)
                mode_solid: rgb_next = cfg_color;
                mode_text:  rgb_next = pix.glyph_on ? cfg_color : black;
                mode_bars:  rgb_next = bar_color;
                mode_blue:  rgb_next = pure_blue;
                default:    rgb_next = black;
            endcase
        end
    end

    // Output register keeps rgb aligned with the syncs
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rgb <= black;
            hs  <= 1'b1;
            vs  <= 1'b1;
        end else begin
            rgb <= rgb_next;
            hs  <= pix.hs;
            vs  <= pix.vs;
        end
    end

endmodule

`default_nettype wire

// ==== spi_config.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_config (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               ss,
    input  wire               sclk,
    input  wire               mosi,
    input  wire               frame_start,
    output logic              miso,
    output vga_pkg::vga_cfg_t cfg
);
    import vga_pkg::*;

    // Pin order is {ss, sclk, mosi}
    logic [2:0]  pin_meta;
    logic [2:0]  pin_sync;
    logic        ss_prev;
    logic        sclk_prev;
    logic        ss_fall;
    logic        ss_rise;
    logic        sclk_rise;
    logic        sclk_fall;
    logic [5:0]  bit_cnt;
    logic [31:0] rx_shift;
    logic [31:0] tx_shift;
    vga_cfg_t    pending;
    logic        pending_valid;

    assign ss_fall   = ss_prev & ~pin_sync[2];
    assign ss_rise   = ~ss_prev & pin_sync[2];
    assign sclk_rise = ~sclk_prev & pin_sync[1] & ~pin_sync[2];
    assign sclk_fall = sclk_prev & ~pin_sync[1] & ~pin_sync[2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pin_meta  <= 3'b100;  // ss idles high
            pin_sync  <= 3'b100;
            ss_prev   <= 1'b1;
            sclk_prev <= 1'b0;
        end else begin
            pin_meta  <= {ss, sclk, mosi};
            pin_sync  <= pin_meta;
            ss_prev   <= pin_sync[2];
            sclk_prev <= pin_sync[1];
        end
    end

    // Receive and readback shift registers
    always_ff @(posedge clk) begin
        if (ss_fall) begin
            tx_shift <= cfg;  // Snapshot for readback
        end else if (sclk_fall) begin
            tx_shift <= {tx_shift[30:0], 1'b0};
        end
        if (sclk_rise) begin
            rx_shift <= {rx_shift[30:0], pin_sync[0]};  // MSB first
        end
        if (ss_rise && bit_cnt == 6'd32) begin
            pending <= vga_cfg_t'(rx_shift);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt       <= '0;
            miso          <= 1'b0;
            pending_valid <= 1'b0;
            cfg           <= cfg_reset_value;
        end else begin
            if (ss_fall) begin
                bit_cnt <= '0;
                miso    <= cfg[31];  // First bit ready before first rise
            end else if (sclk_fall) begin
                miso <= tx_shift[30];
            end else if (ss_rise) begin
                miso <= 1'b0;
            end
            if (sclk_rise && bit_cnt != '1) begin
                bit_cnt <= bit_cnt + 1'b1;  // Saturates so long bursts never alias 32
            end
            // Applied only at a frame boundary
            if (frame_start && pending_valid) begin
                cfg <= pending;
            end
            if (ss_rise && bit_cnt == 6'd32) begin
                pending_valid <= 1'b1;
            end else if (frame_start) begin
                pending_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== vga_text_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_text_top (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           ss,
    input  wire           sclk,
    input  wire           mosi,
    output logic          miso,
    output logic          hs,
    output logic          vs,
    output vga_pkg::rgb_t rgb
);
    import vga_pkg::*;

    scan_pos_t pos;          // Stage 1 output
    cell_pix_t pix;          // Stage 2 output
    vga_cfg_t  cfg;
    logic      frame_start;

    vga_timing i_vga_timing (
        .clk         (clk),
        .rst_n       (rst_n),
        .pos         (pos),
        .frame_start (frame_start)
    );

    cell_decode i_cell_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .pos   (pos),
        .pix   (pix)
    );

    pixel_color i_pixel_color (
        .clk   (clk),
        .rst_n (rst_n),
        .pix   (pix),
        .cfg   (cfg),
        .rgb   (rgb),
        .hs    (hs),
        .vs    (vs)
    );

    // Configuration port, updates land on frame start
    spi_config i_spi_config (
        .clk         (clk),
        .rst_n       (rst_n),
        .ss          (ss),
        .sclk        (sclk),
        .mosi        (mosi),
        .frame_start (frame_start),
        .miso        (miso),
        .cfg         (cfg)
    );

endmodule

`default_nettype wire

// ==== vga_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_checker (
    input wire                    clk,
    input wire                    rst_n,
    input wire                    hs,
    input wire                    vs,
    input wire vga_pkg::rgb_t     rgb,
    input wire vga_pkg::vga_cfg_t cfg,
    input wire                    frame_start
);
    import vga_pkg::*;

    int hs_low_len;  // Consecutive cycles with hs low
    int vs_low_len;
    int fail_count = 0;  // Failed assertions so far

    always @(posedge clk) begin
        if (!rst_n) begin
            hs_low_len <= 0;
            vs_low_len <= 0;
        end else begin
            hs_low_len <= hs ? 0 : hs_low_len + 1;
            vs_low_len <= vs ? 0 : vs_low_len + 1;
        end
    end

    hs_width: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(hs) |-> hs_low_len == h_sync)
        else begin
            fail_count++;
            $error("hs pulse is not %0d cycles wide", h_sync);
        end

    vs_width: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(vs) |-> vs_low_len == v_sync * h_total)
        else begin
            fail_count++;
            $error("vs pulse is not %0d lines wide", v_sync);
        end

    sync_blank: assert property (@(posedge clk) disable iff (!rst_n)
        (!hs || !vs) |-> rgb == '0)
        else begin
            fail_count++;
            $error("rgb not black during a sync pulse");
        end

    // New configuration only one cycle after the frame start pulse
    cfg_update: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(cfg) |-> $past(frame_start))
        else begin
            fail_count++;
            $error("configuration changed away from a frame boundary");
        end

endmodule

`default_nettype wire

// ==== vga_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_monitor (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    hs,
    input  wire                    vs,
    input  wire vga_pkg::rgb_t     rgb,
    input  wire                    ss,
    input  wire                    sclk,
    input  wire                    miso,
    input  wire vga_pkg::vga_cfg_t exp_cfg,
    output int                     err_count,
    output int                     pix_count,
    output int                     bit_count
);
    import vga_pkg::*;

    localparam int max_reports = 20;

    int          hpos;              // Pixel now shown at the ports
    int          vpos;
    vga_cfg_t    cur_cfg;           // Configuration of the current frame
    logic [31:0] rb_shift;          // Expected miso bits, MSB first
    int          rb_idx;
    logic        ss_q;
    logic        sclk_q;
    logic        reset_seen = 1'b0;
    logic        exp_hs;
    logic        exp_vs;

    function automatic logic [5:0] expect_rgb(input vga_cfg_t c, input int x, input int y);
        int   k;
        int   px;
        int   py;
        int   bar;
        logic on;
        if (x >= h_visible || y >= v_visible) begin
            return 6'd0;
        end
        k   = (x / 8 + y / 8) % 4;  // Character code of the cell
        px  = x % 8;
        py  = y % 8;
        bar = x / 80;
        on  = (k == 3) ? (px == py) : (((px ^ py) >> k) % 2 == 1);
        case (c.mode)
            mode_solid: return c.color;
            mode_text:  return on ? c.color : 6'd0;
            mode_bars:  return {bar[2], bar[2], bar[1], bar[1], bar[0], bar[0]};
            default:    return 6'b000011;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [5:0] want,
                                 input logic [5:0] got);
        if (got !== want) begin
            err_count = err_count + 1;
            if (err_count <= max_reports) begin
                $display("ERROR at %0t: %s expected %0h, got %0h (x %0d, y %0d)",
                         $time, name, want, got, hpos, vpos);
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            if (reset_seen) begin
                compare_value("rgb", 6'd0, rgb);
                compare_value("hs", 6'd1, {5'd0, hs});
                compare_value("vs", 6'd1, {5'd0, vs});
                compare_value("miso", 6'd0, {5'd0, miso});
            end else begin
                err_count = 0;
                pix_count = 0;
                bit_count = 0;
            end
            reset_seen = 1'b1;
            hpos       = h_total - 3;  // Three stages ahead of pixel 0 of frame 0
            vpos       = v_total - 1;
            cur_cfg    = exp_cfg;
            ss_q       = 1'b1;
            sclk_q     = 1'b0;
            rb_idx     = 0;
        end else begin
            if (hpos == 0 && vpos == 0) begin
                cur_cfg = exp_cfg;  // Last accepted word takes effect here
            end
            exp_hs = !(hpos >= h_visible + h_front && hpos < h_visible + h_front + h_sync);
            exp_vs = !(vpos >= v_visible + v_front && vpos < v_visible + v_front + v_sync);
            compare_value("rgb", expect_rgb(cur_cfg, hpos, vpos), rgb);
            compare_value("hs", {5'd0, exp_hs}, {5'd0, hs});
            compare_value("vs", {5'd0, exp_vs}, {5'd0, vs});
            pix_count = pix_count + 1;
            hpos      = hpos + 1;
            if (hpos == h_total) begin
                hpos = 0;
                vpos = (vpos == v_total - 1) ? 0 : vpos + 1;
            end
            // Readback returns the configuration applied when ss fell
            if (ss_q && !ss) begin
                rb_shift = cur_cfg;
                rb_idx   = 0;
            end else if (!ss && !sclk_q && sclk) begin
                if (rb_idx < 32) begin
                    compare_value("miso", {5'd0, rb_shift[31]}, {5'd0, miso});
                    bit_count = bit_count + 1;
                end
                rb_shift = {rb_shift[30:0], 1'b0};
                rb_idx   = rb_idx + 1;
            end
            ss_q   = ss;
            sclk_q = sclk;
        end
    end

endmodule

`default_nettype wire

// ==== tb_vga_text.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vga_text;
    import vga_pkg::*;

    typedef struct packed {
        vga_cfg_t   word;        // Sent over SPI
        logic [7:0] nbits;       // Clocks in the transfer
        vga_cfg_t   expect_cfg;  // Configuration from the next frame on
    } spi_row_t;

    localparam int num_rows     = 6;
    localparam int sclk_half    = 8;  // clk cycles per sclk phase
    localparam int frame_cycles = h_total * v_total;

    logic     clk;
    logic     rst_n;
    logic     ss;
    logic     sclk;
    logic     mosi;
    logic     miso;
    logic     hs;
    logic     vs;
    rgb_t     rgb;
    vga_cfg_t exp_cfg;
    vga_cfg_t w;
    vga_cfg_t bad;
    spi_row_t stim [num_rows];
    int       err_count;
    int       pix_count;
    int       bit_count;
    int       gap_lines;

    always #2 clk = ~clk;

    vga_text_top i_vga_text_top (
        .clk   (clk),
        .rst_n (rst_n),
        .ss    (ss),
        .sclk  (sclk),
        .mosi  (mosi),
        .miso  (miso),
        .hs    (hs),
        .vs    (vs),
        .rgb   (rgb)
    );

    vga_monitor i_vga_monitor (
        .clk       (clk),
        .rst_n     (rst_n),
        .hs        (hs),
        .vs        (vs),
        .rgb       (rgb),
        .ss        (ss),
        .sclk      (sclk),
        .miso      (miso),
        .exp_cfg   (exp_cfg),
        .err_count (err_count),
        .pix_count (pix_count),
        .bit_count (bit_count)
    );

    bind vga_text_top vga_checker i_vga_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .hs          (hs),
        .vs          (vs),
        .rgb         (rgb),
        .cfg         (cfg),
        .frame_start (frame_start)
    );

    task automatic hold_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;  // Inputs change just after the edge
    endtask

    task automatic wait_sync(input bit use_vs, input bit level, input int limit);
        logic prev;
        logic cur;
        int   cycles;
        bit   seen;
        prev   = use_vs ? vs : hs;
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(posedge clk);
            cur    = use_vs ? vs : hs;
            seen   = (cur == level) && (prev != level);
            prev   = cur;
            cycles = cycles + 1;
            if (!seen && cycles >= limit) begin
                $display("Timeout: %s did not go %s within %0d cycles",
                         use_vs ? "vs" : "hs", level ? "high" : "low", limit);
                $display(">>> FAIL");
                $finish;
            end
        end
    endtask

    // SPI mode 0, MSB first
    task automatic send_spi(input vga_cfg_t word, input int nbits);
        logic [31:0] data;
        data = word;
        hold_cycles(1);
        ss = 1'b0;
        for (int i = 0; i < nbits; i++) begin
            mosi = (i < 32) ? data[31] : 1'b0;
            data = {data[30:0], 1'b0};
            hold_cycles(sclk_half);
            sclk = 1'b1;
            hold_cycles(sclk_half);
            sclk = 1'b0;
        end
        hold_cycles(sclk_half);
        ss   = 1'b1;
        mosi = 1'b0;
        hold_cycles(sclk_half);
    endtask

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        ss      = 1'b1;
        sclk    = 1'b0;
        mosi    = 1'b0;
        exp_cfg = '{mode: mode_text, color: 6'b111111, reserved: 24'd0};
        void'($urandom(17418));

        w       = '{mode: mode_solid, color: 6'($urandom), reserved: 24'($urandom)};
        stim[0] = '{word: w, nbits: 8'd32, expect_cfg: w};
        w       = '{mode: mode_blue, color: 6'b101010, reserved: 24'd0};
        stim[1] = '{word: w, nbits: 8'd32, expect_cfg: w};
        w       = '{mode: mode_bars, color: 6'b000000, reserved: 24'h00a5a5};
        stim[2] = '{word: w, nbits: 8'd32, expect_cfg: w};
        bad     = '{mode: mode_text, color: 6'b110100, reserved: 24'd0};
        stim[3] = '{word: bad, nbits: 8'd31, expect_cfg: w};  // Short burst is dropped
        bad     = '{mode: mode_solid, color: 6'($urandom), reserved: 24'd0};
        stim[4] = '{word: bad, nbits: 8'd33, expect_cfg: w};  // Long burst is dropped
        w       = '{mode: mode_text, color: 6'($urandom), reserved: 24'h123456};
        stim[5] = '{word: w, nbits: 8'd32, expect_cfg: w};

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        wait_sync(1'b1, 1'b0, 2 * frame_cycles);  // Frame 0 checked in reset config
        for (int r = 0; r < num_rows; r++) begin
            $display("Row %0d: mode %0d, colour %0h, %0d bits",
                     r, stim[r].word.mode, stim[r].word.color, stim[r].nbits);
            wait_sync(1'b1, 1'b1, 2 * frame_cycles);
            gap_lines = 40 + int'($urandom_range(300, 0));  // Write lands mid-frame
            repeat (gap_lines) wait_sync(1'b0, 1'b1, 2 * h_total);
            send_spi(stim[r].word, int'(stim[r].nbits));
            exp_cfg = stim[r].expect_cfg;
            wait_sync(1'b1, 1'b0, 2 * frame_cycles);
            wait_sync(1'b1, 1'b0, 2 * frame_cycles);
        end

        $display("Checked %0d pixels and %0d readback bits, %0d errors, %0d assertion failures",
                 pix_count, bit_count, err_count, i_vga_text_top.i_vga_checker.fail_count);
        if (err_count == 0 && i_vga_text_top.i_vga_checker.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
vga_pkg.sv
vga_timing.sv
cell_decode.sv
pixel_color.sv
spi_config.sv
vga_text_top.sv
vga_checker.sv
vga_monitor.sv
tb_vga_text.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_vga_text -f tb.f
	./obj_dir/Vtb_vga_text > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q ">>> FAIL" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
